//--- common/timer_pkg.sv
package timer_pkg;

  // ********************
  // timing
  localparam int DEFAULT_CYCLES_PER_TICK = 1_000_000;  // clk cycles per fast tick on board
  localparam int TICKS_PER_SECOND        = 100;        // fast ticks in one second
  localparam int TICK_CNT_W              = 7;          // holds 0..99
  localparam int DEBOUNCE_TICKS          = 4;          // steady samples before a press
  localparam int DEBOUNCE_CNT_W          = 3;          // holds 0..4

  typedef logic [TICK_CNT_W-1:0]     tick_cnt_t;  // fast ticks within a second
  typedef logic [DEBOUNCE_CNT_W-1:0] db_cnt_t;    // per button steady count

  // ********************
  // time value
  typedef logic [3:0] bcd_t;  // one decimal digit

  typedef struct packed {
    bcd_t min_tens;  // leftmost digit
    bcd_t min_ones;
    bcd_t sec_tens;
    bcd_t sec_ones;  // rightmost digit
  } mmss_t;

  // ********************
  // control
  typedef enum logic [2:0] {
    TS_SET   = 3'b011,  // encoding goes straight to the leds
    TS_RUN   = 3'b001,
    TS_PAUSE = 3'b010,
    TS_DONE  = 3'b100
  } timer_state_e;

  typedef struct packed {
    logic sec;    // advance seconds
    logic min;    // advance minutes
    logic pause;  // run / pause toggle
    logic start;  // load and go
  } buttons_t;

endpackage

//--- common/display_pkg.sv
package display_pkg;

  // ********************
  // seven segment display
  localparam int SEG_NUMBER_COUNT = 4;  // digits on the board
  localparam int SEG_BIT_WIDTH    = 8;  // a..g plus decimal point
  localparam int SCAN_IDX_W       = 2;  // picks one of four digits

  // active low, bit 0 = a ... bit 6 = g, bit 7 = dp
  typedef logic [SEG_BIT_WIDTH-1:0] seg_t;

  // active low, bit 3 = minute tens ... bit 0 = second ones
  typedef logic [SEG_NUMBER_COUNT-1:0] digit_sel_t;

  typedef logic [SCAN_IDX_W-1:0] scan_idx_t;

  localparam seg_t SEG_BLANK = 8'hFF;  // all segments off

endpackage

//--- hdl/tick_gen.sv
module tick_gen #(
  parameter int CYCLES_PER_TICK = timer_pkg::DEFAULT_CYCLES_PER_TICK
) (
  input  logic clk,          // system clock
  input  logic reset_i,      // sync, active high
  output logic fast_tick_o,  // debounce and scan rate
  output logic sec_tick_o    // one pulse per second
);

  localparam int CYC_W = (CYCLES_PER_TICK > 1) ? $clog2(CYCLES_PER_TICK) : 1;

  logic [CYC_W-1:0]     cyc_cnt;   // clk cycles within a fast tick
  timer_pkg::tick_cnt_t tick_cnt;  // fast ticks within a second

  // ********************
  // clock enable counters
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cyc_cnt  <= '0;
      tick_cnt <= '0;
    end else begin
      if (fast_tick_o) begin
        cyc_cnt <= '0;  // wrap
        if (sec_tick_o) tick_cnt <= '0;
        else tick_cnt <= tick_cnt + 1'b1;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  assign fast_tick_o = (cyc_cnt == CYC_W'(CYCLES_PER_TICK - 1));  // last cycle of period
  assign sec_tick_o  = fast_tick_o &&
                       (tick_cnt == timer_pkg::tick_cnt_t'(timer_pkg::TICKS_PER_SECOND - 1));

endmodule

//--- hdl/button_cond.sv
module button_cond (
  input  logic                clk,          // system clock
  input  logic                reset_i,      // sync, active high
  input  timer_pkg::buttons_t buttons_i,    // raw push buttons
  input  logic                switch_i,     // raw mode switch
  input  logic                fast_tick_i,  // sample enable
  output timer_pkg::buttons_t presses_o,    // one clk pulse per press
  output logic                mode_o        // synchronized switch
);

  timer_pkg::buttons_t                  btn_meta, btn_sync;  // two flop sync
  logic                                 sw_meta, sw_sync;
  logic [$bits(timer_pkg::buttons_t)-1:0] btn_bits;           // indexable view
  logic [$bits(timer_pkg::buttons_t)-1:0] press_bits;

  // ********************
  // synchronizers
  always_ff @(posedge clk) begin
    if (reset_i) begin
      btn_meta <= '0;
      btn_sync <= '0;
      sw_meta  <= 1'b0;
      sw_sync  <= 1'b0;
    end else begin
      btn_meta <= buttons_i;
      btn_sync <= btn_meta;
      sw_meta  <= switch_i;
      sw_sync  <= sw_meta;
    end
  end

  assign btn_bits = btn_sync;

  // ********************
  // debounce, one counter per button
  for (genvar i = 0; i < $bits(timer_pkg::buttons_t); i++) begin : g_db
    timer_pkg::db_cnt_t db_cnt;  // saturates at DEBOUNCE_TICKS
    logic               press_q;
    always_ff @(posedge clk) begin
      if (reset_i) begin
        db_cnt  <= '0;
        press_q <= 1'b0;
      end else begin
        press_q <= 1'b0;  // pulse lasts one cycle
        if (fast_tick_i) begin
          if (!btn_bits[i]) begin
            db_cnt <= '0;  // low sample restarts
          end else if (db_cnt != timer_pkg::db_cnt_t'(timer_pkg::DEBOUNCE_TICKS)) begin
            db_cnt  <= db_cnt + 1'b1;
            press_q <= (db_cnt == timer_pkg::db_cnt_t'(timer_pkg::DEBOUNCE_TICKS - 1));
          end
        end
      end
    end
    assign press_bits[i] = press_q;
  end

  assign presses_o = timer_pkg::buttons_t'(press_bits);
  assign mode_o    = sw_sync;  // level only, no debounce

endmodule

//--- timer/timer_fsm.sv
module timer_fsm (
  input  logic                    clk,         // system clock
  input  logic                    reset_i,     // sync, active high
  input  logic                    start_i,     // start press pulse
  input  logic                    pause_i,     // pause press pulse
  input  logic                    mode_i,      // level, forces setting
  input  logic                    zero_i,      // countdown at 00:00
  output timer_pkg::timer_state_e state_o,     // also shown on leds
  output logic                    load_o,      // copy set time into counter
  output logic                    count_en_o   // counter may decrement
);

  timer_pkg::timer_state_e state_q, state_d;

  // ********************
  // next state
  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    if (mode_i) begin
      state_d = timer_pkg::TS_SET;  // switch wins over everything
    end else begin
      case (state_q)
        timer_pkg::TS_SET: begin
          if (start_i) begin
            state_d = timer_pkg::TS_RUN;
            load_o  = 1'b1;  // same cycle as the move
          end
        end
        timer_pkg::TS_RUN: begin
          if (zero_i) state_d = timer_pkg::TS_DONE;  // expiry before pause
          else if (pause_i) state_d = timer_pkg::TS_PAUSE;
        end
        timer_pkg::TS_PAUSE: begin
          if (pause_i || start_i) state_d = timer_pkg::TS_RUN;  // resume
        end
        timer_pkg::TS_DONE: begin
          if (start_i) state_d = timer_pkg::TS_SET;  // back to setting
        end
        default: state_d = timer_pkg::TS_SET;
      endcase
    end
  end

  // ********************
  // state register
  always_ff @(posedge clk) begin
    if (reset_i) state_q <= timer_pkg::TS_SET;
    else state_q <= state_d;
  end

  assign state_o    = state_q;
  assign count_en_o = (state_q == timer_pkg::TS_RUN);

endmodule

//--- timer/time_setter.sv
module time_setter (
  input  logic                    clk,          // system clock
  input  logic                    reset_i,      // sync, active high
  input  timer_pkg::timer_state_e state_i,      // only advances in setting
  input  logic                    sec_press_i,  // seconds button pulse
  input  logic                    min_press_i,  // minutes button pulse
  output timer_pkg::mmss_t        set_time_o    // time chosen by the user
);

  timer_pkg::mmss_t set_q;

  // next value of a tens:ones pair, 59 wraps to 00
  function automatic logic [7:0] inc_mod60(input timer_pkg::bcd_t tens,
                                           input timer_pkg::bcd_t ones);
    timer_pkg::bcd_t t_n;
    timer_pkg::bcd_t o_n;
    t_n = tens;
    o_n = ones + 1'b1;
    if (ones == 4'd9) begin
      o_n = '0;  // ones roll over
      t_n = (tens == 4'd5) ? 4'd0 : tens + 1'b1;
    end
    return {t_n, o_n};
  endfunction

  // ********************
  // set registers
  always_ff @(posedge clk) begin
    if (reset_i) begin
      set_q <= '0;  // 00:00
    end else if (state_i == timer_pkg::TS_SET) begin
      if (sec_press_i) begin
        {set_q.sec_tens, set_q.sec_ones} <= inc_mod60(set_q.sec_tens, set_q.sec_ones);
      end
      if (min_press_i) begin  // no carry from seconds
        {set_q.min_tens, set_q.min_ones} <= inc_mod60(set_q.min_tens, set_q.min_ones);
      end
    end
  end

  assign set_time_o = set_q;

endmodule

//--- timer/countdown.sv
module countdown (
  input  logic             clk,          // system clock
  input  logic             reset_i,      // sync, active high
  input  logic             load_i,       // capture load_time_i
  input  timer_pkg::mmss_t load_time_i,  // time from the setter
  input  logic             count_en_i,   // running
  input  logic             sec_tick_i,   // one per second
  output timer_pkg::mmss_t cur_time_o,   // remaining time
  output logic             zero_o        // all digits zero
);

  timer_pkg::mmss_t cur_q;
  timer_pkg::mmss_t dec_time;  // cur_q minus one second
  logic             b_sec_tens, b_min_ones, b_min_tens;  // borrow into each digit

  // one digit down, wraps to top on zero
  function automatic timer_pkg::bcd_t dec_digit(input timer_pkg::bcd_t d,
                                                input timer_pkg::bcd_t top);
    return (d == 4'd0) ? top : d - 1'b1;
  endfunction

  // ********************
  // borrow chain
  always_comb begin
    dec_time   = cur_q;
    b_sec_tens = (cur_q.sec_ones == 4'd0);
    b_min_ones = b_sec_tens && (cur_q.sec_tens == 4'd0);  // seconds reload 59
    b_min_tens = b_min_ones && (cur_q.min_ones == 4'd0);
    dec_time.sec_ones = dec_digit(cur_q.sec_ones, 4'd9);
    if (b_sec_tens) dec_time.sec_tens = dec_digit(cur_q.sec_tens, 4'd5);
    if (b_min_ones) dec_time.min_ones = dec_digit(cur_q.min_ones, 4'd9);
    if (b_min_tens) dec_time.min_tens = dec_digit(cur_q.min_tens, 4'd5);
  end

  // ********************
  // counter register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cur_q <= '0;
    end else if (load_i) begin
      cur_q <= load_time_i;
    end else if (count_en_i && sec_tick_i && !zero_o) begin
      cur_q <= dec_time;  // holds at 00:00
    end
  end

  assign cur_time_o = cur_q;
  assign zero_o     = (cur_q == '0);

endmodule

//--- display/ssd_scan.sv
module ssd_scan (
  input  logic                    clk,          // system clock
  input  logic                    reset_i,      // sync, active high
  input  logic                    fast_tick_i,  // next digit
  input  logic                    show_set_i,   // show setter instead of counter
  input  timer_pkg::mmss_t        set_time_i,
  input  timer_pkg::mmss_t        cur_time_i,
  output display_pkg::seg_t       segs_o,       // active low segments
  output display_pkg::digit_sel_t ssd_ctl_o     // active low digit select
);

  display_pkg::scan_idx_t scan_idx;  // 3 = leftmost digit
  timer_pkg::mmss_t       shown;
  timer_pkg::bcd_t        digit;

  // ********************
  // scan counter, 3 2 1 0
  always_ff @(posedge clk) begin
    if (reset_i) scan_idx <= '1;  // start at minute tens
    else if (fast_tick_i) scan_idx <= scan_idx - 1'b1;
  end

  assign shown     = show_set_i ? set_time_i : cur_time_i;
  assign ssd_ctl_o = display_pkg::digit_sel_t'(~(4'b0001 << scan_idx));  // one low

  always_comb begin
    case (scan_idx)
      2'd3:    digit = shown.min_tens;
      2'd2:    digit = shown.min_ones;
      2'd1:    digit = shown.sec_tens;
      default: digit = shown.sec_ones;
    endcase
  end

  // ********************
  // bcd to segments, common anode
  always_comb begin
    case (digit)
      4'd0:    segs_o = 8'hC0;  // a b c d e f
      4'd1:    segs_o = 8'hF9;  // b c
      4'd2:    segs_o = 8'hA4;
      4'd3:    segs_o = 8'hB0;
      4'd4:    segs_o = 8'h99;
      4'd5:    segs_o = 8'h92;
      4'd6:    segs_o = 8'h82;
      4'd7:    segs_o = 8'hF8;
      4'd8:    segs_o = 8'h80;  // all on, dp off
      4'd9:    segs_o = 8'h90;
      default: segs_o = display_pkg::SEG_BLANK;  // not a digit
    endcase
  end

endmodule

//--- hdl/countdown_timer_top.sv
module countdown_timer_top #(
  parameter int CYCLES_PER_TICK = timer_pkg::DEFAULT_CYCLES_PER_TICK
) (
  input  logic                    clk,        // board clock
  input  logic                    reset_i,    // sync, active high
  input  timer_pkg::buttons_t     buttons_i,  // raw push buttons
  input  logic                    switch_i,   // mode switch
  output logic [15:0]             led_o,      // state and expiry lamps
  output display_pkg::seg_t       segs_o,     // segment lines
  output display_pkg::digit_sel_t ssd_ctl_o   // digit selects
);

  logic                    fast_tick, sec_tick;
  timer_pkg::buttons_t     presses;
  logic                    mode_sync;
  timer_pkg::timer_state_e state;
  logic                    load, count_en, count_zero;
  timer_pkg::mmss_t        set_time, cur_time;

  // ********************
  // timing and inputs
  tick_gen #(.CYCLES_PER_TICK(CYCLES_PER_TICK)) i_tick_gen (
    .clk(clk), .reset_i(reset_i),
    .fast_tick_o(fast_tick), .sec_tick_o(sec_tick)
  );

  button_cond i_button_cond (
    .clk(clk), .reset_i(reset_i), .buttons_i(buttons_i), .switch_i(switch_i),
    .fast_tick_i(fast_tick), .presses_o(presses), .mode_o(mode_sync)
  );

  // ********************
  // control and counters
  timer_fsm i_timer_fsm (
    .clk(clk), .reset_i(reset_i), .start_i(presses.start), .pause_i(presses.pause),
    .mode_i(mode_sync), .zero_i(count_zero),
    .state_o(state), .load_o(load), .count_en_o(count_en)
  );

  time_setter i_time_setter (
    .clk(clk), .reset_i(reset_i), .state_i(state),
    .sec_press_i(presses.sec), .min_press_i(presses.min), .set_time_o(set_time)
  );

  countdown i_countdown (
    .clk(clk), .reset_i(reset_i), .load_i(load), .load_time_i(set_time),
    .count_en_i(count_en), .sec_tick_i(sec_tick),
    .cur_time_o(cur_time), .zero_o(count_zero)
  );

  // ********************
  // display
  ssd_scan i_ssd_scan (
    .clk(clk), .reset_i(reset_i), .fast_tick_i(fast_tick),
    .show_set_i(state == timer_pkg::TS_SET),  // setter shown only while setting
    .set_time_i(set_time), .cur_time_i(cur_time),
    .segs_o(segs_o), .ssd_ctl_o(ssd_ctl_o)
  );

  assign led_o[2:0]  = state;  // raw state encoding
  assign led_o[15:3] = {13{count_zero && (state == timer_pkg::TS_DONE)}};  // expired

endmodule

//--- bench/countdown_timer_assertions.sv
module countdown_timer_assertions (
  input logic                    clk,        // DUT clock
  input logic                    reset_i,    // DUT reset
  input logic [15:0]             led_i,      // DUT led_o
  input display_pkg::digit_sel_t ssd_ctl_i   // DUT ssd_ctl_o
);

  int fail_count = 0;  // read by the testbench at the end

  // ********************
  // display and leds
  a_one_digit: assert property (@(posedge clk) disable iff (reset_i)
    $countones(~ssd_ctl_i) <= 1)
    else begin fail_count++; $error("several digit selects low: %b", ssd_ctl_i); end

  a_led_bar: assert property (@(posedge clk) disable iff (reset_i)
    led_i[15:3] == '0 || led_i[15:3] == '1)
    else begin fail_count++; $error("upper leds mixed: %b", led_i[15:3]); end

  a_reset_state: assert property (@(posedge clk)
    reset_i |=> led_i[2:0] == timer_pkg::TS_SET)
    else begin fail_count++; $error("state after reset is %b", led_i[2:0]); end

endmodule

bind countdown_timer_top countdown_timer_assertions i_assertions (
  .clk(clk), .reset_i(reset_i), .led_i(led_o), .ssd_ctl_i(ssd_ctl_o)
);

//--- bench/tb_countdown_timer.sv
module tb_countdown_timer;

  localparam int CYCLES_PER_TICK = 4;
  localparam int SEC_CYCLES      = 100 * CYCLES_PER_TICK;  // clk cycles per second
  localparam int HOLD_CYCLES     = 8 * CYCLES_PER_TICK;    // 8 fast ticks
  localparam int JITTER          = 40;                     // display polling slack
  // twice the length of 12 s of countdown and 140 presses of 64 cycles
  localparam int MAX_CYCLES      = 30000;

  localparam timer_pkg::buttons_t PRESS_SEC   = '{sec: 1'b1, default: 1'b0};
  localparam timer_pkg::buttons_t PRESS_MIN   = '{min: 1'b1, default: 1'b0};
  localparam timer_pkg::buttons_t PRESS_PAUSE = '{pause: 1'b1, default: 1'b0};
  localparam timer_pkg::buttons_t PRESS_START = '{start: 1'b1, default: 1'b0};

  logic                    clk;
  logic                    reset;
  timer_pkg::buttons_t     buttons;
  logic                    switch_in;
  logic [15:0]             led;
  display_pkg::seg_t       segs;
  display_pkg::digit_sel_t ssd_ctl;
  int unsigned             cycle_cnt = 0;
  int                      seed;
  int                      exp_sec, exp_min;  // set time model

  countdown_timer_top #(.CYCLES_PER_TICK(CYCLES_PER_TICK)) i_dut (
    .clk(clk), .reset_i(reset), .buttons_i(buttons), .switch_i(switch_in),
    .led_o(led), .segs_o(segs), .ssd_ctl_o(ssd_ctl)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_equal(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
      $display("Verification failed");
      $fatal(1, "check failed");
    end
  endtask

  // ********************
  // display helpers
  function automatic logic [3:0] seg_to_digit(input display_pkg::seg_t s);
    logic [6:0] lit;  // lit segments g down to a
    lit = ~s[6:0];
    case (lit)
      7'b0111111: return 4'd0;  // a b c d e f
      7'b0000110: return 4'd1;
      7'b1011011: return 4'd2;
      7'b1001111: return 4'd3;
      7'b1100110: return 4'd4;
      7'b1101101: return 4'd5;
      7'b1111101: return 4'd6;
      7'b0000111: return 4'd7;
      7'b1111111: return 4'd8;
      7'b1101111: return 4'd9;
      default:    return 4'hF;  // blank or garbage
    endcase
  endfunction

  function automatic timer_pkg::mmss_t to_mmss(input int m, input int s);
    return {4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
  endfunction

  task automatic read_display(output timer_pkg::mmss_t t);
    logic [3:0] d [4];
    for (int k = 3; k >= 0; k--) begin
      do @(negedge clk); while (ssd_ctl !== display_pkg::digit_sel_t'(~(4'b0001 << k)));
      check_equal("segs_o[7]", 1, 32'(segs[7]));  // dp stays dark
      d[k] = seg_to_digit(segs);
    end
    t = {d[3], d[2], d[1], d[0]};
  endtask

  task automatic wait_time(input timer_pkg::mmss_t t, output int cycles);
    timer_pkg::mmss_t shown;
    int unsigned t0;
    t0 = cycle_cnt;
    do read_display(shown); while (shown !== t);
    cycles = cycle_cnt - t0;
  endtask

  task automatic wait_state(input timer_pkg::timer_state_e s);
    do @(negedge clk); while (led[2:0] !== s);
  endtask

  // ********************
  // stimulus
  task automatic apply_reset();
    @(posedge clk);
    reset     <= 1'b1;
    buttons   <= '0;
    switch_in <= 1'b0;
    repeat (2) @(posedge clk);
    reset   <= 1'b0;
    exp_sec = 0;
    exp_min = 0;
  endtask

  task automatic press_button(input timer_pkg::buttons_t b);
    @(posedge clk);
    buttons <= b;
    repeat (HOLD_CYCLES) @(posedge clk);
    buttons <= '0;
    repeat (HOLD_CYCLES) @(posedge clk);
    @(negedge clk);  // outputs settled
    if (b.sec) exp_sec = (exp_sec == 59) ? 0 : exp_sec + 1;
    if (b.min) exp_min = (exp_min == 59) ? 0 : exp_min + 1;
  endtask

  // ********************
  // directed tests
  task automatic reset_defaults();
    timer_pkg::mmss_t shown;
    apply_reset();
    @(negedge clk);
    check_equal("ssd_ctl_o", 32'(4'b0111), 32'(ssd_ctl));  // leftmost digit first
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_SET), 32'(led[2:0]));
    check_equal("led_o[15:3]", 0, 32'(led[15:3]));
    read_display(shown);
    check_equal("display", 32'(to_mmss(0, 0)), 32'(shown));
  endtask

  task automatic set_time_wrap();
    timer_pkg::mmss_t shown;
    int sec_n, min_n;
    sec_n = 60 + ($random(seed) & 7);  // always crosses 59
    min_n = 60 + ($random(seed) & 7);
    repeat (sec_n) press_button(PRESS_SEC);
    read_display(shown);
    check_equal("display", 32'(to_mmss(0, sec_n % 60)), 32'(shown));
    repeat (min_n) press_button(PRESS_MIN);  // no carry into seconds
    read_display(shown);
    check_equal("display", 32'(to_mmss(min_n % 60, sec_n % 60)), 32'(shown));
  endtask

  task automatic count_to_zero();
    int cyc;
    apply_reset();
    repeat (3) press_button(PRESS_SEC);
    press_button(PRESS_START);
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_RUN), 32'(led[2:0]));
    wait_time(to_mmss(0, 2), cyc);
    check_equal("first_sec_in_time", 1, 32'(cyc <= SEC_CYCLES));
    for (int s = 1; s >= 0; s--) begin
      wait_time(to_mmss(0, s), cyc);
      check_equal("sec_interval_ok", 1, 32'(cyc > SEC_CYCLES - JITTER &&
                                              cyc < SEC_CYCLES + JITTER));
    end
    wait_state(timer_pkg::TS_DONE);
    check_equal("led_o[15:3]", 32'(13'h1FFF), 32'(led[15:3]));
    press_button(PRESS_START);  // done back to setting
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_SET), 32'(led[2:0]));
    check_equal("led_o[15:3]", 0, 32'(led[15:3]));
    apply_reset();
    press_button(PRESS_MIN);
    press_button(PRESS_START);
    wait_time(to_mmss(0, 59), cyc);  // borrow reloads 59
    check_equal("first_sec_in_time", 1, 32'(cyc <= SEC_CYCLES));
  endtask

  task automatic pause_and_resume();
    timer_pkg::mmss_t shown;
    int cyc;
    apply_reset();
    repeat (5) press_button(PRESS_SEC);
    press_button(PRESS_START);
    wait_time(to_mmss(0, 4), cyc);
    press_button(PRESS_PAUSE);
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_PAUSE), 32'(led[2:0]));
    repeat (2 * SEC_CYCLES) @(negedge clk);
    read_display(shown);
    check_equal("display", 32'(to_mmss(0, 4)), 32'(shown));  // frozen
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_PAUSE), 32'(led[2:0]));
    press_button(PRESS_PAUSE);
    check_equal("led_o[2:0]", 32'(timer_pkg::TS_RUN), 32'(led[2:0]));
    wait_time(to_mmss(0, 3), cyc);
    check_equal("first_sec_in_time", 1, 32'(cyc <= SEC_CYCLES));
  endtask

  // runs on from pause_and_resume while it still counts down
  task automatic mode_forces_set();
    timer_pkg::mmss_t shown;
    @(posedge clk);
    switch_in <= 1'b1;
    wait_state(timer_pkg::TS_SET);
    read_display(shown);
    check_equal("display", 32'(to_mmss(exp_min, exp_sec)), 32'(shown));  // set time kept
    @(posedge clk);
    switch_in <= 1'b0;
  endtask

  initial begin
    seed      = 82;
    reset     = 1'b1;
    buttons   = '0;
    switch_in = 1'b0;
    reset_defaults();
    set_time_wrap();
    count_to_zero();
    pause_and_resume();
    mode_forces_set();
    if (i_dut.i_assertions.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sources.f
common/timer_pkg.sv
common/display_pkg.sv
hdl/tick_gen.sv
hdl/button_cond.sv
timer/timer_fsm.sv
timer/time_setter.sv
timer/countdown.sv
display/ssd_scan.sv
hdl/countdown_timer_top.sv
bench/countdown_timer_assertions.sv
bench/tb_countdown_timer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the countdown timer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_countdown_timer
./obj_dir/Vtb_countdown_timer | tee sim.log
if grep -q "^Verification passed$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
